/* arrayAllocator.sv */
/*
  Array allocator: per-array allocation bits, count of numbers handed out
  from the never-used pool, and a LIFO stack of freed array numbers
*/
`default_nettype none

module arrayAllocator import memPkg::*; #(
  parameter int addressBits = defaultAddressBits
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   clearAll,
  input  logic                   allocate,
  input  logic                   deallocate,
  input  logic [addressBits-1:0] releaseArray,
  input  logic [addressBits-1:0] queryArray,
  output logic                   queryAllocated,
  output logic                   queryEverUsed,
  output logic [addressBits-1:0] nextArray,
  output logic                   outOfMemory
);

  localparam int arrays = 2 ** addressBits;

  logic [arrays-1:0]      allocated;              // One bit per array
  logic [addressBits:0]   everCount;              // Never-used numbers handed out
  logic [addressBits:0]   stackTop;               // Entries on the freed stack
  logic [addressBits-1:0] freedStack [arrays];
  logic [addressBits-1:0] topIndex;
  logic                   stackEmpty;

  assign stackEmpty = stackTop == '0;
  assign topIndex   = stackTop[addressBits-1:0] - 1'b1;

  // ----------------------------
  // Lookups, no wait
  // ----------------------------
  assign queryAllocated = allocated[queryArray];
  assign queryEverUsed  = {1'b0, queryArray} < everCount;
  assign nextArray      = stackEmpty ? everCount[addressBits-1:0] : freedStack[topIndex];
  assign outOfMemory    = stackEmpty && everCount == {1'b1, {addressBits{1'b0}}};

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      everCount <= '0;
      stackTop  <= '0;
    end else if (clearAll) begin
      allocated <= '0;
      everCount <= '0;
      stackTop  <= '0;
    end else if (allocate) begin
      allocated[nextArray] <= 1'b1;
      if (stackEmpty) everCount <= everCount + 1'b1;  // Fresh number
      else            stackTop  <= stackTop - 1'b1;   // Reuse last freed
    end else if (deallocate) begin
      allocated[releaseArray] <= 1'b0;
      stackTop                <= stackTop + 1'b1;
    end
  end

  // A released array is allocated, so the stack always has room for it
  always_ff @(posedge clock) begin
    if (deallocate && !clearAll && !allocate) begin
      freedStack[stackTop[addressBits-1:0]] <= releaseArray;
    end
  end

endmodule

`default_nettype wire

/* arrayExecute.sv */
/*
  Execute stage: element storage, per-array sizes, request checks and the
  single-cycle update of storage, sizes and allocator
*/
`default_nettype none

module arrayExecute import memPkg::*; #(
  parameter int addressBits = defaultAddressBits,
  parameter int indexBits   = defaultIndexBits,
  parameter int dataBits    = defaultDataBits
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   decValid,
  input  decodedOp               decOp,
  input  logic [addressBits-1:0] decArray,
  input  logic [indexBits-1:0]   decIndex,
  input  logic [dataBits-1:0]    decData,
  output logic                   exeValid,
  output logic [dataBits-1:0]    exeData,
  output errorCode               exeError
);

  localparam int arrays      = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;
  localparam logic [indexBits:0] fullSize = {1'b1, {indexBits{1'b0}}};

  logic [dataBits-1:0]    elements [arrays][arrayLength];
  logic [indexBits:0]     sizes    [arrays];

  logic                   queryAllocated, queryEverUsed, outOfMemory;
  logic [addressBits-1:0] nextArray;
  logic [indexBits:0]     curSize;
  logic [indexBits-1:0]   topIndex;               // Last element, for pop
  logic [dataBits-1:0]    curElem, aluResult, respData;
  logic                   needsArray, accepted;
  errorCode               checkError;

  assign curSize  = sizes[decArray];
  assign topIndex = curSize[indexBits-1:0] - 1'b1;
  assign curElem  = elements[decArray][decIndex];

  assign needsArray = !(decOp.kind inside {opNone, opClearAll, opAllocate});

  // ----------------------------
  // Checks, in priority order
  // ----------------------------
  always_comb begin
    checkError = errNone;
    if (decOp.kind == opAllocate) begin
      if (outOfMemory) checkError = errOutOfMemory;
    end else if (needsArray) begin
      if (!queryEverUsed)                                      checkError = errNotAllocated;
      else if (!queryAllocated)                                checkError = errFreed;
      else if (decOp.checkIndex && {1'b0, decIndex} >= curSize) checkError = errOutOfBounds;
      else if (decOp.kind == opPushOp && curSize == fullSize)  checkError = errArrayFull;
      else if (decOp.kind == opPopOp && curSize == '0)         checkError = errArrayEmpty;
    end
  end

  assign accepted = decValid && checkError == errNone;

  always_comb begin
    case (decOp.kind)
      opAllocate:  respData = dataBits'(nextArray);
      opStore:     respData = decData;
      opLoad:      respData = curElem;
      opSizeQuery: respData = dataBits'(curSize);
      opPushOp:    respData = decData;
      opPopOp:     respData = elements[decArray][topIndex];
      opModify:    respData = decOp.returnOld ? curElem : aluResult;
      default:     respData = '0;                 // Reset, free and idle
    endcase
  end

  arrayAllocator #(.addressBits(addressBits)) i_allocator (
    .clock          (clock),
    .resetN         (resetN),
    .clearAll       (accepted && decOp.kind == opClearAll),
    .allocate       (accepted && decOp.kind == opAllocate),
    .deallocate     (accepted && decOp.kind == opRelease),
    .releaseArray   (decArray),
    .queryArray     (decArray),
    .queryAllocated (queryAllocated),
    .queryEverUsed  (queryEverUsed),
    .nextArray      (nextArray),
    .outOfMemory    (outOfMemory)
  );

  elementAlu #(.dataBits(dataBits)) i_alu (
    .operand (curElem),
    .amount  (decData),
    .alu     (decOp.alu),
    .result  (aluResult)
  );

  // ----------------------------
  // Storage and size update
  // ----------------------------
  always_ff @(posedge clock) begin
    if (accepted) begin
      case (decOp.kind)
        opAllocate: sizes[nextArray] <= '0;      // New array starts empty
        opStore: begin
          elements[decArray][decIndex] <= decData;
          if ({1'b0, decIndex} >= curSize) sizes[decArray] <= {1'b0, decIndex} + 1'b1;
        end
        opPushOp: begin
          elements[decArray][curSize[indexBits-1:0]] <= decData;
          sizes[decArray] <= curSize + 1'b1;
        end
        opPopOp:  sizes[decArray] <= curSize - 1'b1;
        opModify: elements[decArray][decIndex] <= aluResult;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) exeValid <= 1'b0;
    else         exeValid <= decValid;
  end

  always_ff @(posedge clock) begin
    exeData  <= respData;
    exeError <= checkError;
  end

endmodule

`default_nettype wire

/* arrayMemory.sv */
/*
  Array memory top level: decode, execute and result stages in a
  three-cycle pipeline
*/
`default_nettype none

module arrayMemory import memPkg::*; #(
  parameter int addressBits = defaultAddressBits,
  parameter int indexBits   = defaultIndexBits,
  parameter int dataBits    = defaultDataBits
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   start,
  input  arrayAction             action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  output logic                   done,
  output logic [dataBits-1:0]    dataOut,
  output errorCode               error
);

  logic                   decValid, exeValid;
  decodedOp               decOp;
  logic [addressBits-1:0] decArray;
  logic [indexBits-1:0]   decIndex;
  logic [dataBits-1:0]    decData, exeData;
  errorCode               exeError;

  opDecoder #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) i_decoder (
    .clock, .resetN, .start, .action, .array, .index, .dataIn,
    .decValid, .decOp, .decArray, .decIndex, .decData
  );

  arrayExecute #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    i_execute (
    .clock, .resetN, .decValid, .decOp, .decArray, .decIndex, .decData,
    .exeValid, .exeData, .exeError
  );

  resultStage #(.dataBits(dataBits)) i_result (
    .clock, .resetN, .exeValid, .exeData, .exeError,
    .done, .dataOut, .error
  );

endmodule

`default_nettype wire

/* arrayMemoryTb.sv */
/*
  Directed testbench for the array memory: clock and reset, request tasks,
  reference model, tests and the closing report
*/
`default_nettype none

module arrayMemoryTb import memPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int addressBits   = defaultAddressBits;
  localparam int indexBits     = defaultIndexBits;
  localparam int dataBits      = defaultDataBits;
  localparam int arrays        = 2 ** addressBits;
  localparam int arrayLength   = 2 ** indexBits;
  localparam int timeoutCycles = 20;

  logic                   clock, resetN, start, done;
  arrayAction             action;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    dataIn, dataOut;
  errorCode               error;

  // ----------------------------
  // Reference model state
  // ----------------------------
  logic [dataBits-1:0] modelMem [arrays][arrayLength];
  int                  modelSize [arrays];
  bit                  modelAlloc [arrays];
  int                  modelFresh;                // Never-used numbers handed out
  int                  freedStack [$];            // LIFO of freed arrays

  int                  mismatchCount, timeoutCount;
  logic [dataBits-1:0] lastData;
  errorCode            lastError;

  arrayMemory #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) i_dut (
    .clock, .resetN, .start, .action, .array, .index, .dataIn,
    .done, .dataOut, .error
  );

  always #2 clock = ~clock;                       // 4 ns period

  function automatic logic [dataBits-1:0] applyOp(input arrayAction act,
      input logic [dataBits-1:0] old, input logic [dataBits-1:0] amt);
    case (act)
      actAdd, actAddAfter:      return old + amt;
      actSubtract, actSubAfter: return old - amt;
      actShiftLeft:             return (amt >= dataBits) ? '0 : old << amt;
      actShiftRight:            return (amt >= dataBits) ? '0 : old >> amt;
      actBitNot:                return ~old;
      actBitOr:                 return old | amt;
      actBitXor:                return old ^ amt;
      default:                  return old & amt;
    endcase
  endfunction

  task automatic predictResponse(input arrayAction act, input int arr, input int idx,
      input logic [dataBits-1:0] data, output logic [dataBits-1:0] expData,
      output errorCode expError);
    int n;
    logic [dataBits-1:0] old, updated;
    expData  = '0;
    expError = errNone;
    old      = modelMem[arr][idx];
    if (act == actReset) begin
      foreach (modelAlloc[a]) modelAlloc[a] = 1'b0;
      modelFresh = 0;
      freedStack.delete();
    end else if (act == actAlloc) begin
      n = -1;
      if (freedStack.size() > 0) begin
        n = freedStack.pop_back();                // Last freed comes back first
      end else if (modelFresh < arrays) begin
        n = modelFresh;
        modelFresh++;
      end else begin
        expError = errOutOfMemory;
      end
      if (n >= 0) begin
        modelAlloc[n] = 1'b1;
        modelSize[n]  = 0;
        expData       = dataBits'(n);
      end
    end else if (arr >= modelFresh) begin
      expError = errNotAllocated;
    end else if (!modelAlloc[arr]) begin
      expError = errFreed;
    end else if ((act == actRead || act >= actAdd) && idx >= modelSize[arr]) begin
      expError = errOutOfBounds;
    end else if (act == actPush && modelSize[arr] == arrayLength) begin
      expError = errArrayFull;
    end else if (act == actPop && modelSize[arr] == 0) begin
      expError = errArrayEmpty;
    end else begin
      case (act)
        actWrite: begin
          modelMem[arr][idx] = data;
          if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;
          expData = data;
        end
        actRead: expData = old;
        actSize: expData = dataBits'(modelSize[arr]);
        actPush: begin
          modelMem[arr][modelSize[arr]] = data;
          modelSize[arr]++;
          expData = data;
        end
        actPop: begin
          modelSize[arr]--;
          expData = modelMem[arr][modelSize[arr]];
        end
        actFree: begin
          modelAlloc[arr] = 1'b0;
          freedStack.push_back(arr);
        end
        default: begin
          updated            = applyOp(act, old, data);
          modelMem[arr][idx] = updated;
          expData = (act == actAddAfter || act == actSubAfter) ? old : updated;
        end
      endcase
    end
  endtask

  // ----------------------------
  // Request driving and checking
  // ----------------------------
  task automatic driveRequest(input arrayAction act, input int arr, input int idx,
      input logic [dataBits-1:0] data);
    start  <= 1'b1;
    action <= act;
    array  <= addressBits'(arr);
    index  <= indexBits'(idx);
    dataIn <= data;
  endtask

  task automatic reportCounts();
    $display("errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
  endtask

  task automatic collectResponse(input arrayAction act);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clock);                           // Outputs settle after the edge
      cycles++;
    end while (!done && cycles < timeoutCycles);
    if (!done) begin
      timeoutCount++;
      $display("no done for the %s request within %0d cycles", act.name(), timeoutCycles);
      reportCounts();
      $display("Testbench failed");
      $finish;
    end else begin
      lastData  = dataOut;
      lastError = error;
    end
  endtask

  task automatic doRequest(input arrayAction act, input int arr, input int idx,
      input logic [dataBits-1:0] data);
    @(posedge clock);
    driveRequest(act, arr, idx, data);
    @(posedge clock);
    start <= 1'b0;                                // Single cycle pulse
    collectResponse(act);
  endtask

  task automatic checkResponse(input arrayAction act, input logic [dataBits-1:0] expData,
      input errorCode expError);
    assert (lastError === expError) else begin
      mismatchCount++;
      $display("mismatch error on %s: got %h expected %h", act.name(), lastError, expError);
    end
    assert (lastData === expData) else begin
      mismatchCount++;
      $display("mismatch dataOut on %s: got %h expected %h", act.name(), lastData, expData);
    end
  endtask

  task automatic checkedRequest(input arrayAction act, input int arr, input int idx,
      input logic [dataBits-1:0] data);
    logic [dataBits-1:0] expData;
    errorCode expError;
    predictResponse(act, arr, idx, data, expData, expError);
    doRequest(act, arr, idx, data);
    checkResponse(act, expData, expError);
  endtask

  task automatic expectData(input logic [dataBits-1:0] expected);
    assert (lastData === expected) else begin
      mismatchCount++;
      $display("mismatch dataOut: got %h expected %h", lastData, expected);
    end
  endtask

  // ----------------------------
  // Tests
  // ----------------------------
  task automatic allocationTest();
    for (int n = 0; n < arrays; n++) begin
      checkedRequest(actAlloc, 0, 0, '0);
      expectData(dataBits'(n));
    end
    checkedRequest(actAlloc, 0, 0, '0);           // All in use
    checkedRequest(actFree, 2, 0, '0);
    checkedRequest(actFree, 1, 0, '0);
    checkedRequest(actAlloc, 0, 0, '0);
    expectData(dataBits'(1));
    checkedRequest(actAlloc, 0, 0, '0);
    expectData(dataBits'(2));
    checkedRequest(actReset, 0, 0, '0);
    checkedRequest(actAlloc, 0, 0, '0);
    expectData('0);
  endtask

  task automatic accessTest();
    checkedRequest(actReset, 0, 0, '0);
    checkedRequest(actAlloc, 0, 0, '0);
    checkedRequest(actAlloc, 0, 0, '0);
    checkedRequest(actWrite, 0, 2, dataBits'($urandom));
    checkedRequest(actSize, 0, 0, '0);            // Grown to three
    checkedRequest(actRead, 0, 2, '0);
    checkedRequest(actRead, 0, 3, '0);            // Past the end
    checkedRequest(actWrite, 0, 0, dataBits'($urandom));
    checkedRequest(actRead, 0, 0, '0);
    checkedRequest(actSize, 0, 0, '0);
    checkedRequest(actRead, 3, 0, '0);            // Never allocated
    checkedRequest(actFree, 1, 0, '0);
    checkedRequest(actWrite, 1, 0, dataBits'($urandom));
    checkedRequest(actFree, 1, 0, '0);            // Double free
  endtask

  task automatic pushPopTest();
    checkedRequest(actReset, 0, 0, '0);
    checkedRequest(actAlloc, 0, 0, '0);
    for (int i = 0; i <= arrayLength; i++) checkedRequest(actPush, 0, 0, dataBits'($urandom));
    checkedRequest(actSize, 0, 0, '0);
    for (int i = 0; i <= arrayLength; i++) checkedRequest(actPop, 0, 0, '0);
  endtask

  task automatic elementTest();
    arrayAction ops [10] = '{actAdd, actAddAfter, actSubtract, actSubAfter, actShiftLeft,
                             actShiftRight, actBitNot, actBitOr, actBitXor, actBitAnd};
    logic [dataBits-1:0] amount;
    int idx;
    checkedRequest(actReset, 0, 0, '0);
    checkedRequest(actAlloc, 0, 0, '0);
    for (int i = 0; i < arrayLength; i++) checkedRequest(actWrite, 0, i, dataBits'($urandom));
    for (int round = 0; round < 3; round++) begin
      foreach (ops[k]) begin
        idx    = $urandom % arrayLength;
        amount = dataBits'($urandom);
        if (ops[k] == actShiftLeft || ops[k] == actShiftRight) amount = dataBits'($urandom % 16);
        checkedRequest(ops[k], 0, idx, amount);
        checkedRequest(actRead, 0, idx, '0);
      end
    end
  endtask

  // Back to back requests, three in flight
  task automatic pipelineTest();
    arrayAction          burst [3] = '{actWrite, actAdd, actRead};
    logic [dataBits-1:0] amounts [3];
    logic [dataBits-1:0] expData [3];
    errorCode            expError [3];
    checkedRequest(actReset, 0, 0, '0);
    checkedRequest(actAlloc, 0, 0, '0);
    foreach (burst[k]) begin
      amounts[k] = dataBits'($urandom);
      predictResponse(burst[k], 0, 1, amounts[k], expData[k], expError[k]);
    end
    foreach (burst[k]) begin
      @(posedge clock);
      driveRequest(burst[k], 0, 1, amounts[k]);
    end
    @(posedge clock);
    start <= 1'b0;
    foreach (burst[k]) begin
      collectResponse(burst[k]);
      checkResponse(burst[k], expData[k], expError[k]);
    end
  endtask

  initial begin
    void'($urandom(32'h19fa_32d5));
    clock         = 1'b0;
    resetN        = 1'b0;
    start         = 1'b0;
    action        = actIdle;
    array         = '0;
    index         = '0;
    dataIn        = '0;
    mismatchCount = 0;
    timeoutCount  = 0;
    modelFresh    = 0;
    repeat (3) @(posedge clock);
    resetN <= 1'b1;
    allocationTest();
    accessTest();
    pushPopTest();
    elementTest();
    pipelineTest();
    reportCounts();
    if (mismatchCount + timeoutCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* arrayMemory_assertions.sv */
/*
  Concurrent checks on the array memory handshake and outputs,
  bound into the top level
*/
`default_nettype none

module arrayMemoryAssertions import memPkg::*; #(
  parameter int dataBits = defaultDataBits
) (
  input logic                clock,
  input logic                resetN,
  input logic                start,
  input logic                done,
  input logic [dataBits-1:0] dataOut,
  input errorCode            error
);

  timeunit 1ns;
  timeprecision 100ps;

  doneLowInReset: assert property (@(posedge clock) !resetN |-> !done)
    else $error("done is high while reset is asserted");

  // Fixed three-stage latency
  startToDone: assert property (@(posedge clock) disable iff (!resetN) start |-> ##3 done)
    else $error("done did not follow start after three cycles");

  quietOnError: assert property (@(posedge clock) disable iff (!resetN)
    error != errNone |-> dataOut == '0)
    else $error("dataOut is not zero while an error is reported");

endmodule

bind arrayMemory arrayMemoryAssertions #(.dataBits(dataBits)) i_assertions (
  .clock   (clock),
  .resetN  (resetN),
  .start   (start),
  .done    (done),
  .dataOut (dataOut),
  .error   (error)
);

`default_nettype wire

/* elementAlu.sv */
/*
  Element ALU: arithmetic, shift and bitwise update of one array element
*/
`default_nettype none

module elementAlu import memPkg::*; #(
  parameter int dataBits = defaultDataBits
) (
  input  logic [dataBits-1:0] operand,
  input  logic [dataBits-1:0] amount,
  input  aluOp                alu,
  output logic [dataBits-1:0] result
);

  logic shiftOut;                                 // Shift moves every bit out

  assign shiftOut = amount >= dataBits;

  always_comb begin
    case (alu)
      aluAdd:        result = operand + amount;
      aluSubtract:   result = operand - amount;  // Wraps modulo 2**dataBits
      aluShiftLeft: begin
        if (shiftOut) result = '0;
        else          result = operand << amount;
      end
      aluShiftRight: begin
        if (shiftOut) result = '0;
        else          result = operand >> amount;
      end
      aluBitNot:     result = ~operand;
      aluBitOr:      result = operand | amount;
      aluBitXor:     result = operand ^ amount;
      aluBitAnd:     result = operand & amount;
      default:       result = operand;           // Pass
    endcase
  end

endmodule

`default_nettype wire

/* memPkg.sv */
/*
  Shared types for the array memory: request actions, element operations,
  execute classes, error codes, the decoded-operation struct and default sizes
*/
`default_nettype none

package memPkg;

  // ----------------------------
  // Request actions
  // ----------------------------
  typedef enum logic [4:0] {
    actIdle       = 5'd0,
    actReset      = 5'd1,
    actWrite      = 5'd2,
    actRead       = 5'd3,
    actSize       = 5'd4,
    actPush       = 5'd5,
    actPop        = 5'd6,
    actAlloc      = 5'd7,
    actFree       = 5'd8,
    actAdd        = 5'd9,
    actAddAfter   = 5'd10,
    actSubtract   = 5'd11,
    actSubAfter   = 5'd12,
    actShiftLeft  = 5'd13,
    actShiftRight = 5'd14,
    actBitNot     = 5'd15,
    actBitOr      = 5'd16,
    actBitXor     = 5'd17,
    actBitAnd     = 5'd18
  } arrayAction;

  typedef enum logic [3:0] {
    aluPass, aluAdd, aluSubtract, aluShiftLeft, aluShiftRight,
    aluBitNot, aluBitOr, aluBitXor, aluBitAnd
  } aluOp;

  // What the execute stage does with a request
  typedef enum logic [3:0] {
    opNone, opClearAll, opAllocate, opRelease, opStore,
    opLoad, opSizeQuery, opPushOp, opPopOp, opModify
  } opClass;

  typedef enum logic [2:0] {
    errNone, errNotAllocated, errFreed, errOutOfBounds,
    errArrayFull, errArrayEmpty, errOutOfMemory
  } errorCode;

  typedef struct packed {
    opClass kind;                                 // Execute class
    aluOp   alu;                                  // Element operation
    logic   checkIndex;                           // Index must be below size
    logic   returnOld;                            // Respond with value before update
  } decodedOp;

  // ----------------------------
  // Default sizes
  // ----------------------------
  localparam int defaultAddressBits = 2;          // Four arrays
  localparam int defaultIndexBits   = 2;          // Four elements each
  localparam int defaultDataBits    = 12;

endpackage

`default_nettype wire

/* opDecoder.sv */
/*
  Decode stage: maps a request action onto an execute class, an element
  operation and check flags, registered together with the request fields
*/
`default_nettype none

module opDecoder import memPkg::*; #(
  parameter int addressBits = defaultAddressBits,
  parameter int indexBits   = defaultIndexBits,
  parameter int dataBits    = defaultDataBits
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   start,
  input  arrayAction             action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  output logic                   decValid,
  output decodedOp               decOp,
  output logic [addressBits-1:0] decArray,
  output logic [indexBits-1:0]   decIndex,
  output logic [dataBits-1:0]    decData
);

  decodedOp nextOp;

  always_comb begin
    nextOp = '{kind: opNone, alu: aluPass, checkIndex: 1'b0, returnOld: 1'b0};
    case (action)
      actReset:      nextOp.kind = opClearAll;
      actWrite:      nextOp.kind = opStore;       // Index past end extends
      actRead:       nextOp = '{opLoad, aluPass, 1'b1, 1'b0};
      actSize:       nextOp.kind = opSizeQuery;
      actPush:       nextOp.kind = opPushOp;
      actPop:        nextOp.kind = opPopOp;
      actAlloc:      nextOp.kind = opAllocate;
      actFree:       nextOp.kind = opRelease;
      actAdd:        nextOp = '{opModify, aluAdd, 1'b1, 1'b0};
      actAddAfter:   nextOp = '{opModify, aluAdd, 1'b1, 1'b1};
      actSubtract:   nextOp = '{opModify, aluSubtract, 1'b1, 1'b0};
      actSubAfter:   nextOp = '{opModify, aluSubtract, 1'b1, 1'b1};
      actShiftLeft:  nextOp = '{opModify, aluShiftLeft, 1'b1, 1'b0};
      actShiftRight: nextOp = '{opModify, aluShiftRight, 1'b1, 1'b0};
      actBitNot:     nextOp = '{opModify, aluBitNot, 1'b1, 1'b0};
      actBitOr:      nextOp = '{opModify, aluBitOr, 1'b1, 1'b0};
      actBitXor:     nextOp = '{opModify, aluBitXor, 1'b1, 1'b0};
      actBitAnd:     nextOp = '{opModify, aluBitAnd, 1'b1, 1'b0};
      default:       nextOp.kind = opNone;        // Idle and unknown codes
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      decValid <= 1'b0;
      decOp    <= '0;
    end else begin
      decValid <= start;
      decOp    <= nextOp;
    end
  end

  // Request fields ride along with the decode
  always_ff @(posedge clock) begin
    decArray <= array;
    decIndex <= index;
    decData  <= dataIn;
  end

endmodule

`default_nettype wire

/* resultStage.sv */
/*
  Result stage: done pulse, held output word and error code
*/
`default_nettype none

module resultStage import memPkg::*; #(
  parameter int dataBits = defaultDataBits
) (
  input  logic                clock,
  input  logic                resetN,
  input  logic                exeValid,
  input  logic [dataBits-1:0] exeData,
  input  errorCode            exeError,
  output logic                done,
  output logic [dataBits-1:0] dataOut,
  output errorCode            error
);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done    <= 1'b0;
      dataOut <= '0;
      error   <= errNone;
    end else begin
      done <= exeValid;                           // One pulse per response
      if (exeValid) begin
        error <= exeError;
        // Failed requests never leak data
        dataOut <= (exeError == errNone) ? exeData : '0;
      end
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the array memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module arrayMemoryTb \
  -f vlog.f --Mdir obj_dir -o arrayMemorySim
if [ $? -ne 0 ]; then
  echo "Verilator compile step failed"
  exit 1
fi

./obj_dir/arrayMemorySim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Testbench failed" "$logFile"; then
  exit 1
fi
exit 0

/* vlog.f */
memPkg.sv
opDecoder.sv
elementAlu.sv
arrayAllocator.sv
arrayExecute.sv
resultStage.sv
arrayMemory.sv
arrayMemory_assertions.sv
arrayMemoryTb.sv
